//--- core_pkg.sv
// RV32I subset core definitions
`default_nettype none

package core_pkg;

  ////////////////////////////////////////
  // widths and sizes
  ////////////////////////////////////////

  // data word width
  localparam int unsigned XLEN      = 32;
  // RAM depth in words
  localparam int unsigned MEM_WORDS = 1024;
  // RAM word address width
  localparam int unsigned MEM_AW    = 10;

  // data or instruction word
  typedef logic [XLEN-1:0] word_t;
  // byte address
  typedef logic [31:0]     addr_t;
  // register index
  typedef logic [4:0]      reg_idx_t;

  ////////////////////////////////////////
  // decoder and FSM encodings
  ////////////////////////////////////////

  // ALU operations
  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_XOR    = 3'd4,
    ALU_PASS_B = 3'd5
  } alu_op_t;

  // instruction classes
  typedef enum logic [3:0] {
    OP_ALU       = 4'd0,
    OP_ALUI      = 4'd1,
    OP_LUI       = 4'd2,
    OP_LOAD      = 4'd3,
    OP_STORE     = 4'd4,
    OP_BRANCH_EQ = 4'd5,
    OP_BRANCH_NE = 4'd6,
    OP_JAL       = 4'd7,
    OP_HALT      = 4'd8
  } op_kind_t;

  // decoded control
  typedef struct packed {
    op_kind_t kind;
    alu_op_t  alu_op;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    // sign-extended, already selected by format
    word_t    imm;
    logic     rd_wen;
  } ctl_t;

  // core FSM states
  typedef enum logic [2:0] {
    ST_IDLE  = 3'd0,
    ST_FETCH = 3'd1,
    ST_EXEC  = 3'd2,
    ST_MEM   = 3'd3,
    ST_WB    = 3'd4,
    ST_HALT  = 3'd5
  } core_state_t;

  // bus request payload
  typedef struct packed {
    logic  wen;
    addr_t adr;
    word_t wdt;
  } bus_req_t;

endpackage

`default_nettype wire

//--- rv_decode.sv
// Instruction decoder
`timescale 1ns/10ps
`default_nettype none

module rv_decode (
  input  core_pkg::word_t inst,
  output core_pkg::ctl_t  ctl
);

  import core_pkg::*;

  // instruction fields
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  // immediates per format
  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_u;
  word_t imm_j;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // sign extension from bit 31 in every format
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    // unknown encodings fall through as halt, no rd write
    ctl.kind   = OP_HALT;
    ctl.alu_op = ALU_ADD;
    ctl.rd     = inst[11:7];
    ctl.rs1    = inst[19:15];
    ctl.rs2    = inst[24:20];
    ctl.imm    = '0;
    ctl.rd_wen = 1'b0;
    case (opcode)
      // register-register
      7'b0110011: begin
        if (funct7 == 7'b0000000 && funct3 == 3'b000) begin
          ctl.kind   = OP_ALU;
          ctl.alu_op = ALU_ADD;
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          ctl.kind   = OP_ALU;
          ctl.alu_op = ALU_SUB;
        end else if (funct7 == 7'b0000000 && funct3 == 3'b111) begin
          ctl.kind   = OP_ALU;
          ctl.alu_op = ALU_AND;
        end else if (funct7 == 7'b0000000 && funct3 == 3'b110) begin
          ctl.kind   = OP_ALU;
          ctl.alu_op = ALU_OR;
        end else if (funct7 == 7'b0000000 && funct3 == 3'b100) begin
          ctl.kind   = OP_ALU;
          ctl.alu_op = ALU_XOR;
        end
        ctl.rd_wen = (ctl.kind == OP_ALU);
      end
      // addi only
      7'b0010011: begin
        if (funct3 == 3'b000) begin
          ctl.kind   = OP_ALUI;
          ctl.imm    = imm_i;
          ctl.rd_wen = 1'b1;
        end
      end
      // lui passes the immediate through the ALU
      7'b0110111: begin
        ctl.kind   = OP_LUI;
        ctl.alu_op = ALU_PASS_B;
        ctl.imm    = imm_u;
        ctl.rd_wen = 1'b1;
      end
      // lw, address from ALU add
      7'b0000011: begin
        if (funct3 == 3'b010) begin
          ctl.kind   = OP_LOAD;
          ctl.imm    = imm_i;
          ctl.rd_wen = 1'b1;
        end
      end
      // sw
      7'b0100011: begin
        if (funct3 == 3'b010) begin
          ctl.kind = OP_STORE;
          ctl.imm  = imm_s;
        end
      end
      // beq/bne compare by subtraction
      7'b1100011: begin
        ctl.alu_op = ALU_SUB;
        ctl.imm    = imm_b;
        if (funct3 == 3'b000) begin
          ctl.kind = OP_BRANCH_EQ;
        end else if (funct3 == 3'b001) begin
          ctl.kind = OP_BRANCH_NE;
        end
      end
      // jal
      7'b1101111: begin
        ctl.kind   = OP_JAL;
        ctl.imm    = imm_j;
        ctl.rd_wen = 1'b1;
      end
      default: begin
        ctl.kind = OP_HALT;
      end
    endcase
    // x0 is never a write target
    if (ctl.rd == '0) begin
      ctl.rd_wen = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- rv_gpr.sv
// General purpose register file
`timescale 1ns/10ps
`default_nettype none

module rv_gpr (
  input  logic               clk,
  input  logic               rst,
  input  core_pkg::reg_idx_t rs1,
  input  core_pkg::reg_idx_t rs2,
  input  core_pkg::reg_idx_t rd,
  input  logic               wen,
  input  core_pkg::word_t    wdt,
  output core_pkg::word_t    rs1_dat,
  output core_pkg::word_t    rs2_dat
);

  import core_pkg::*;

  // x1..x31, x0 has no storage
  word_t gpr [1:31];

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        gpr[i] <= '0;
      end
    end else if (wen && rd != '0) begin
      gpr[rd] <= wdt;
    end
  end

  // combinational reads, x0 reads as zero
  assign rs1_dat = (rs1 == '0) ? '0 : gpr[rs1];
  assign rs2_dat = (rs2 == '0) ? '0 : gpr[rs2];

  // decoder masks rd_wen for x0, so a load into x0 never reaches here
  assert property (@(posedge clk) disable iff (rst) !(wen && rd == '0 && wdt != '0));

endmodule

`default_nettype wire

//--- rv_alu.sv
// Arithmetic and logic unit
`timescale 1ns/10ps
`default_nettype none

module rv_alu (
  input  core_pkg::alu_op_t op,
  input  core_pkg::word_t   a,
  input  core_pkg::word_t   b,
  output core_pkg::word_t   y,
  output logic              zero
);

  import core_pkg::*;

  always_comb begin
    case (op)
      ALU_ADD: begin
        y = a + b;
      end
      // also the branch comparator
      ALU_SUB: begin
        y = a - b;
      end
      ALU_AND: begin
        y = a & b;
      end
      ALU_OR: begin
        y = a | b;
      end
      ALU_XOR: begin
        y = a ^ b;
      end
      // lui
      ALU_PASS_B: begin
        y = b;
      end
      default: begin
        y = '0;
      end
    endcase
  end

  // equal operands when op is sub
  assign zero = (y == '0);

endmodule

`default_nettype wire

//--- rv_core.sv
// Multi-cycle RV32I subset core
`timescale 1ns/10ps
`default_nettype none

module rv_core (
  input  logic               clk,
  input  logic               rst,
  input  logic               run,
  output logic               halted,
  // instruction fetch bus
  output core_pkg::bus_req_t if_req,
  output logic               if_vld,
  input  logic               if_rdy,
  input  core_pkg::word_t    if_rdt,
  input  logic               if_rsp_vld,
  // load/store bus
  output core_pkg::bus_req_t ls_req,
  output logic               ls_vld,
  input  logic               ls_rdy,
  input  core_pkg::word_t    ls_rdt,
  input  logic               ls_rsp_vld
);

  import core_pkg::*;

  core_state_t state;
  addr_t       pc;
  word_t       ir;
  // fetch transferred, response due
  logic        rsp_wait;
  ctl_t        ctl;
  word_t       rs1_dat;
  word_t       rs2_dat;
  word_t       alu_b;
  word_t       alu_y;
  logic        alu_zero;
  logic        taken;
  addr_t       pc_inc;
  addr_t       pc_tgt;
  addr_t       pc_nxt;
  logic        gpr_wen;
  word_t       gpr_wdt;

  ////////////////////////////////////////
  // decode and execute datapath
  ////////////////////////////////////////

  rv_decode i_rv_decode (.inst(ir), .ctl(ctl));

  rv_gpr i_rv_gpr (
    .clk(clk), .rst(rst), .rs1(ctl.rs1), .rs2(ctl.rs2), .rd(ctl.rd),
    .wen(gpr_wen), .wdt(gpr_wdt), .rs1_dat(rs1_dat), .rs2_dat(rs2_dat)
  );

  // operand b: rs2 for reg-reg and branches, else immediate
  assign alu_b = (ctl.kind == OP_ALU || ctl.kind == OP_BRANCH_EQ ||
                  ctl.kind == OP_BRANCH_NE) ? rs2_dat : ctl.imm;

  rv_alu i_rv_alu (.op(ctl.alu_op), .a(rs1_dat), .b(alu_b), .y(alu_y), .zero(alu_zero));

  // branch decision from the shared subtractor
  assign taken  = (ctl.kind == OP_BRANCH_EQ && alu_zero) ||
                  (ctl.kind == OP_BRANCH_NE && !alu_zero);
  assign pc_inc = pc + 32'd4;
  assign pc_tgt = pc + ctl.imm;
  assign pc_nxt = (taken || ctl.kind == OP_JAL) ? pc_tgt : pc_inc;

  // writeback in exec for non-loads, in wb for loads
  assign gpr_wen = (state == ST_EXEC && ctl.rd_wen && ctl.kind != OP_LOAD) ||
                   (state == ST_WB && ls_rsp_vld && ctl.rd_wen);
  assign gpr_wdt = (state == ST_WB) ? ls_rdt : (ctl.kind == OP_JAL) ? pc_inc : alu_y;

  ////////////////////////////////////////
  // bus masters
  ////////////////////////////////////////

  assign if_req = '{wen: 1'b0, adr: pc, wdt: '0};
  assign if_vld = (state == ST_FETCH) && !rsp_wait;
  // address from alu add, store data from rs2
  assign ls_req = '{wen: (ctl.kind == OP_STORE), adr: alu_y, wdt: rs2_dat};
  assign ls_vld = (state == ST_MEM);
  assign halted = (state == ST_HALT);

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state    <= ST_IDLE;
      pc       <= '0;
      rsp_wait <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (run) state <= ST_FETCH;
        end
        ST_FETCH: begin
          if (if_vld && if_rdy) rsp_wait <= 1'b1;
          if (if_rsp_vld) begin
            rsp_wait <= 1'b0;
            state    <= ST_EXEC;
          end
        end
        ST_EXEC: begin
          case (ctl.kind)
            OP_LOAD, OP_STORE: state <= ST_MEM;
            OP_HALT: state <= ST_HALT;
            default: begin
              pc    <= pc_nxt;
              state <= ST_FETCH;
            end
          endcase
        end
        // hold request until granted
        ST_MEM: begin
          if (ls_vld && ls_rdy) begin
            if (ctl.kind == OP_LOAD) begin
              state <= ST_WB;
            end else begin
              pc    <= pc_inc;
              state <= ST_FETCH;
            end
          end
        end
        ST_WB: begin
          if (ls_rsp_vld) begin
            pc    <= pc_inc;
            state <= ST_FETCH;
          end
        end
        // left only by reset
        ST_HALT: state <= ST_HALT;
        default: state <= ST_IDLE;
      endcase
    end
  end

  // instruction register
  always_ff @(posedge clk) begin
    if (state == ST_FETCH && if_rsp_vld) ir <= if_rdt;
  end

  assert property (@(posedge clk) disable iff (rst) !(if_vld && ls_vld));
  assert property (@(posedge clk) disable iff (rst)
    if_vld && !if_rdy |=> if_vld && $stable(if_req));
  assert property (@(posedge clk) disable iff (rst)
    ls_vld && !ls_rdy |=> ls_vld && $stable(ls_req));

endmodule

`default_nettype wire

//--- mem_arbiter.sv
// Fixed-priority memory arbiter
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter (
  input  logic                        clk,
  input  logic                        rst,
  // host port, highest priority
  input  core_pkg::bus_req_t          host_req,
  input  logic                        host_vld,
  output logic                        host_rdy,
  output core_pkg::word_t             host_rdt,
  output logic                        host_rsp_vld,
  // load/store port
  input  core_pkg::bus_req_t          ls_req,
  input  logic                        ls_vld,
  output logic                        ls_rdy,
  output core_pkg::word_t             ls_rdt,
  output logic                        ls_rsp_vld,
  // fetch port, lowest priority
  input  core_pkg::bus_req_t          if_req,
  input  logic                        if_vld,
  output logic                        if_rdy,
  output core_pkg::word_t             if_rdt,
  output logic                        if_rsp_vld,
  // RAM side
  output logic                        mem_en,
  output logic                        mem_wen,
  output logic [core_pkg::MEM_AW-1:0] mem_adr,
  output core_pkg::word_t             mem_wdt,
  input  core_pkg::word_t             mem_rdt
);

  import core_pkg::*;

  bus_req_t   gnt_req;
  // read owner, one bit per port: {fetch, load/store, host}
  logic [2:0] rd_own;

  // grant in the request cycle
  assign host_rdy = host_vld;
  assign ls_rdy   = ls_vld && !host_vld;
  assign if_rdy   = if_vld && !host_vld && !ls_vld;

  assign gnt_req = host_rdy ? host_req : ls_rdy ? ls_req : if_req;
  assign mem_en  = host_rdy || ls_rdy || if_rdy;
  assign mem_wen = mem_en && gnt_req.wen;
  // byte address 11:2 selects the word
  assign mem_adr = gnt_req.adr[MEM_AW+1:2];
  assign mem_wdt = gnt_req.wdt;

  // remember who gets the next read data
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      rd_own <= '0;
    end else begin
      rd_own <= {if_rdy, ls_rdy, host_rdy} & {3{mem_en && !mem_wen}};
    end
  end

  // read data shared, qualified per port
  assign host_rdt     = mem_rdt;
  assign ls_rdt       = mem_rdt;
  assign if_rdt       = mem_rdt;
  assign host_rsp_vld = rd_own[0];
  assign ls_rsp_vld   = rd_own[1];
  assign if_rsp_vld   = rd_own[2];

  assert property (@(posedge clk) disable iff (rst) $onehot0({host_rdy, ls_rdy, if_rdy}));

endmodule

`default_nettype wire

//--- sram_mem.sv
// Single-port word RAM
`timescale 1ns/10ps
`default_nettype none

module sram_mem (
  input  logic                        clk,
  input  logic                        en,
  input  logic                        wen,
  input  logic [core_pkg::MEM_AW-1:0] adr,
  input  core_pkg::word_t             wdt,
  output core_pkg::word_t             rdt
);

  import core_pkg::*;

  // storage array
  word_t mem [MEM_WORDS];

  // write, or read into the output register
  always_ff @(posedge clk) begin
    if (en) begin
      if (wen) begin
        mem[adr] <= wdt;
      end else begin
        // rdt holds its value on writes
        rdt <= mem[adr];
      end
    end
  end

endmodule

`default_nettype wire

//--- soc_top.sv
// Core and memory subsystem top
`timescale 1ns/10ps
`default_nettype none

module soc_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               run,
  output logic               halted,
  // host port
  input  core_pkg::bus_req_t host_req,
  input  logic               host_vld,
  output logic               host_rdy,
  output core_pkg::word_t    host_rdt,
  output logic               host_rsp_vld
);

  import core_pkg::*;

  // fetch bus
  bus_req_t             if_req;
  logic                 if_vld;
  logic                 if_rdy;
  word_t                if_rdt;
  logic                 if_rsp_vld;
  // load/store bus
  bus_req_t             ls_req;
  logic                 ls_vld;
  logic                 ls_rdy;
  word_t                ls_rdt;
  logic                 ls_rsp_vld;
  // RAM
  logic                 mem_en;
  logic                 mem_wen;
  logic [MEM_AW-1:0]    mem_adr;
  word_t                mem_wdt;
  word_t                mem_rdt;

  rv_core i_rv_core (
    .clk(clk), .rst(rst), .run(run), .halted(halted),
    .if_req(if_req), .if_vld(if_vld), .if_rdy(if_rdy),
    .if_rdt(if_rdt), .if_rsp_vld(if_rsp_vld),
    .ls_req(ls_req), .ls_vld(ls_vld), .ls_rdy(ls_rdy),
    .ls_rdt(ls_rdt), .ls_rsp_vld(ls_rsp_vld)
  );

  mem_arbiter i_mem_arbiter (
    .clk(clk), .rst(rst),
    .host_req(host_req), .host_vld(host_vld), .host_rdy(host_rdy),
    .host_rdt(host_rdt), .host_rsp_vld(host_rsp_vld),
    .ls_req(ls_req), .ls_vld(ls_vld), .ls_rdy(ls_rdy),
    .ls_rdt(ls_rdt), .ls_rsp_vld(ls_rsp_vld),
    .if_req(if_req), .if_vld(if_vld), .if_rdy(if_rdy),
    .if_rdt(if_rdt), .if_rsp_vld(if_rsp_vld),
    .mem_en(mem_en), .mem_wen(mem_wen), .mem_adr(mem_adr),
    .mem_wdt(mem_wdt), .mem_rdt(mem_rdt)
  );

  sram_mem i_sram_mem (
    .clk(clk), .en(mem_en), .wen(mem_wen), .adr(mem_adr), .wdt(mem_wdt), .rdt(mem_rdt)
  );

endmodule

`default_nettype wire

//--- tb_clock.sv
// Testbench clock and reset
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
  input  logic rst_req,
  output logic clk,
  output logic rst
);

  // 40 ns period
  localparam int unsigned HALF_NS    = 20;
  // reset length in clock cycles
  localparam logic [2:0]  RST_CYCLES = 3'd5;

  logic       clk_q   = 1'b0;
  logic [2:0] rst_cnt = RST_CYCLES;

  always #(HALF_NS) clk_q = ~clk_q;
  assign clk = clk_q;

  // reset held while the counter runs, restarted on request
  always @(posedge clk_q) begin
    if (rst_req) begin
      rst_cnt <= RST_CYCLES;
    end else if (rst_cnt != 3'd0) begin
      rst_cnt <= rst_cnt - 3'd1;
    end
  end

  assign rst = (rst_cnt != 3'd0);

endmodule

`default_nettype wire

//--- tb_soc.sv
// SoC testbench
`timescale 1ns/10ps
`default_nettype none

module tb_soc;

  import core_pkg::*;

  ////////////////////////////////////////
  // run limits and memory layout
  ////////////////////////////////////////

  localparam int unsigned SEED        = 32'h4b33;
  localparam int unsigned NUM_PROGS   = 4;
  localparam int unsigned MAX_INSTS   = 512;
  // programs x instructions x 10 cycles x 40 ns
  localparam int unsigned WATCHDOG_NS = NUM_PROGS * MAX_INSTS * 10 * 40;
  // program in words 0..63, data in 64..127 (byte 0x100)
  localparam int unsigned PROG_WORDS  = 64;
  localparam int unsigned DATA_BASE   = 64;
  localparam int unsigned DATA_WORDS  = 64;
  // never touched by programs
  localparam int unsigned FREE_BASE   = 512;
  localparam word_t       EBREAK      = 32'h00100073;

  logic     clk;
  logic     rst;
  logic     rst_req;
  logic     run;
  logic     halted;
  bus_req_t host_req;
  logic     host_vld;
  logic     host_rdy;
  word_t    host_rdt;
  logic     host_rsp_vld;

  // expected RAM contents, kept in step with host writes
  word_t shadow [MEM_WORDS];
  word_t iss_mem [MEM_WORDS];
  word_t data [DATA_WORDS];
  word_t prog [$];

  tb_clock i_tb_clock (.rst_req(rst_req), .clk(clk), .rst(rst));

  soc_top i_soc_top (
    .clk(clk), .rst(rst), .run(run), .halted(halted),
    .host_req(host_req), .host_vld(host_vld), .host_rdy(host_rdy),
    .host_rdt(host_rdt), .host_rsp_vld(host_rsp_vld)
  );

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "run aborted");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      $display("=== FAIL ===");
      $fatal(1, "word mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      $display("=== FAIL ===");
      $fatal(1, "flag mismatch");
    end
  endtask

  ////////////////////////////////////////
  // host port
  ////////////////////////////////////////

  task automatic wait_host_grant();
    int unsigned waited;
    waited = 0;
    @(negedge clk);
    while (!host_rdy) begin
      waited++;
      if (waited > 16) abort_run("host request was never granted");
      @(negedge clk);
    end
  endtask

  task automatic host_write(input addr_t addr, input word_t wdata);
    @(posedge clk);
    host_req <= '{wen: 1'b1, adr: addr, wdt: wdata};
    host_vld <= 1'b1;
    wait_host_grant();
    @(posedge clk);
    host_vld <= 1'b0;
    shadow[addr[11:2]] = wdata;
    // writes give no response
    @(negedge clk);
    check_flag("host_rsp_vld", host_rsp_vld, 1'b0);
  endtask

  task automatic host_read(input addr_t addr, output word_t rdata);
    @(posedge clk);
    host_req <= '{wen: 1'b0, adr: addr, wdt: '0};
    host_vld <= 1'b1;
    wait_host_grant();
    @(posedge clk);
    host_vld <= 1'b0;
    // response exactly one cycle after the transfer
    @(negedge clk);
    check_flag("host_rsp_vld", host_rsp_vld, 1'b1);
    rdata = host_rdt;
  endtask

  // odd multiplier, so every word address gives its own value
  function automatic word_t fill_word(input int unsigned w);
    return word_t'(w) * 32'h9e3779b1 + 32'h13572468;
  endfunction

  ////////////////////////////////////////
  // instruction encoders
  ////////////////////////////////////////

  function automatic word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                  input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic word_t enc_addi(input reg_idx_t rd, input reg_idx_t rs1,
                                     input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic word_t enc_lw(input reg_idx_t rd, input reg_idx_t rs1,
                                   input logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, 7'b0000011};
  endfunction

  function automatic word_t enc_sw(input reg_idx_t rs2, input reg_idx_t rs1,
                                   input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  // f3 0 is beq, 1 is bne
  function automatic word_t enc_b(input logic [2:0] f3, input reg_idx_t rs1,
                                  input reg_idx_t rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic word_t enc_lui(input reg_idx_t rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic word_t enc_jal(input reg_idx_t rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  ////////////////////////////////////////
  // reference instruction-set model
  ////////////////////////////////////////

  // runs iss_mem in place, returns executed count
  function automatic int unsigned iss_run();
    word_t       x [32];
    addr_t       pc;
    addr_t       npc;
    addr_t       ea;
    word_t       inst;
    word_t       res;
    word_t       a;
    word_t       b;
    word_t       imm_i;
    word_t       imm_s;
    word_t       imm_b;
    word_t       imm_j;
    logic [2:0]  f3;
    logic [6:0]  f7;
    reg_idx_t    rd;
    logic        wr;
    logic        stop;
    int unsigned n;
    for (int i = 0; i < 32; i++) begin
      x[i] = '0;
    end
    pc   = '0;
    n    = 0;
    stop = 1'b0;
    while (!stop && n < MAX_INSTS) begin
      inst  = iss_mem[pc[11:2]];
      f3    = inst[14:12];
      f7    = inst[31:25];
      rd    = inst[11:7];
      a     = x[inst[19:15]];
      b     = x[inst[24:20]];
      imm_i = {{20{inst[31]}}, inst[31:20]};
      imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      npc   = pc + 32'd4;
      wr    = 1'b0;
      res   = '0;
      n++;
      case (inst[6:0])
        7'b0110011: begin
          wr = 1'b1;
          if (f7 == 7'h00 && f3 == 3'd0) res = a + b;
          else if (f7 == 7'h20 && f3 == 3'd0) res = a - b;
          else if (f7 == 7'h00 && f3 == 3'd7) res = a & b;
          else if (f7 == 7'h00 && f3 == 3'd6) res = a | b;
          else if (f7 == 7'h00 && f3 == 3'd4) res = a ^ b;
          else begin
            wr   = 1'b0;
            stop = 1'b1;
          end
        end
        7'b0010011: begin
          wr   = (f3 == 3'd0);
          stop = (f3 != 3'd0);
          res  = a + imm_i;
        end
        7'b0110111: begin
          wr  = 1'b1;
          res = {inst[31:12], 12'h000};
        end
        7'b0000011: begin
          ea   = a + imm_i;
          wr   = (f3 == 3'd2);
          stop = (f3 != 3'd2);
          res  = iss_mem[ea[11:2]];
        end
        7'b0100011: begin
          ea = a + imm_s;
          if (f3 == 3'd2) iss_mem[ea[11:2]] = b;
          else stop = 1'b1;
        end
        7'b1100011: begin
          if ((f3 == 3'd0 && a == b) || (f3 == 3'd1 && a != b)) npc = pc + imm_b;
          else if (f3 > 3'd1) stop = 1'b1;
        end
        7'b1101111: begin
          wr  = 1'b1;
          res = npc;
          npc = pc + imm_j;
        end
        // ebreak and everything unsupported
        default: stop = 1'b1;
      endcase
      if (wr && rd != '0) x[rd] = res;
      if (!stop) pc = npc;
    end
    return n;
  endfunction

  ////////////////////////////////////////
  // programs
  ////////////////////////////////////////

  task automatic build_alu_prog();
    prog.delete();
    prog.push_back(enc_addi(5'd1, 5'd0, 12'h123));
    prog.push_back(enc_addi(5'd2, 5'd0, 12'hffb));
    prog.push_back(enc_lui(5'd3, 20'habcde));
    prog.push_back(enc_r(7'h00, 3'd0, 5'd4, 5'd1, 5'd2));
    prog.push_back(enc_r(7'h20, 3'd0, 5'd5, 5'd1, 5'd2));
    prog.push_back(enc_r(7'h00, 3'd7, 5'd6, 5'd3, 5'd2));
    prog.push_back(enc_r(7'h00, 3'd6, 5'd7, 5'd1, 5'd3));
    prog.push_back(enc_r(7'h00, 3'd4, 5'd8, 5'd2, 5'd3));
    prog.push_back(enc_addi(5'd9, 5'd3, 12'h7ff));
    prog.push_back(enc_addi(5'd10, 5'd0, 12'h100));
    // x3..x9 to 0x100..0x118
    for (int r = 3; r < 10; r++) begin
      prog.push_back(enc_sw(5'(r), 5'd10, 12'((r - 3) * 4)));
    end
    prog.push_back(EBREAK);
  endtask

  // copy 8 words 0x100 -> 0x140, sum to 0x160
  task automatic build_copy_prog();
    prog.delete();
    prog.push_back(enc_addi(5'd10, 5'd0, 12'h100));
    prog.push_back(enc_addi(5'd11, 5'd0, 12'h140));
    prog.push_back(enc_addi(5'd12, 5'd0, 12'h000));
    prog.push_back(enc_addi(5'd13, 5'd0, 12'h008));
    prog.push_back(enc_lw(5'd5, 5'd10, 12'h000));
    prog.push_back(enc_sw(5'd5, 5'd11, 12'h000));
    prog.push_back(enc_r(7'h00, 3'd0, 5'd12, 5'd12, 5'd5));
    prog.push_back(enc_addi(5'd10, 5'd10, 12'h004));
    prog.push_back(enc_addi(5'd11, 5'd11, 12'h004));
    prog.push_back(enc_addi(5'd13, 5'd13, 12'hfff));
    prog.push_back(enc_b(3'd1, 5'd13, 5'd0, 13'h1fe8));
    prog.push_back(enc_sw(5'd12, 5'd11, 12'h000));
    // x0 must stay zero through addi and lw
    prog.push_back(enc_addi(5'd0, 5'd0, 12'h055));
    prog.push_back(enc_lw(5'd0, 5'd0, 12'h104));
    prog.push_back(enc_sw(5'd0, 5'd0, 12'h164));
    prog.push_back(EBREAK);
  endtask

  task automatic build_branch_prog();
    prog.delete();
    // bne loop, 5 x 3
    prog.push_back(enc_addi(5'd1, 5'd0, 12'h005));
    prog.push_back(enc_addi(5'd2, 5'd0, 12'h000));
    prog.push_back(enc_addi(5'd2, 5'd2, 12'h003));
    prog.push_back(enc_addi(5'd1, 5'd1, 12'hfff));
    prog.push_back(enc_b(3'd1, 5'd1, 5'd0, 13'h1ff8));
    prog.push_back(enc_addi(5'd10, 5'd0, 12'h100));
    prog.push_back(enc_sw(5'd2, 5'd10, 12'h000));
    // beq exit from a jal back-loop
    prog.push_back(enc_addi(5'd3, 5'd0, 12'h000));
    prog.push_back(enc_addi(5'd4, 5'd0, 12'h004));
    prog.push_back(enc_addi(5'd3, 5'd3, 12'h001));
    prog.push_back(enc_b(3'd0, 5'd3, 5'd4, 13'h0008));
    prog.push_back(enc_jal(5'd0, 21'h1ffff8));
    prog.push_back(enc_sw(5'd3, 5'd10, 12'h004));
    // jal link and a skipped instruction
    prog.push_back(enc_jal(5'd5, 21'h000008));
    prog.push_back(enc_addi(5'd6, 5'd0, 12'h063));
    prog.push_back(enc_sw(5'd5, 5'd10, 12'h008));
    prog.push_back(enc_sw(5'd6, 5'd10, 12'h00c));
    prog.push_back(enc_b(3'd1, 5'd0, 5'd0, 13'h0008));
    prog.push_back(enc_b(3'd0, 5'd0, 5'd0, 13'h0008));
    prog.push_back(enc_addi(5'd7, 5'd0, 12'h001));
    prog.push_back(enc_sw(5'd7, 5'd10, 12'h010));
    prog.push_back(EBREAK);
  endtask

  // forward-only control flow, so it always reaches the ebreak
  task automatic build_random_prog();
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    int unsigned pick;
    prog.delete();
    // x10 is the data pointer, never a target
    prog.push_back(enc_addi(5'd10, 5'd0, 12'h100));
    repeat (40) begin
      rd   = 5'($urandom_range(9));
      rs1  = 5'($urandom_range(10));
      rs2  = 5'($urandom_range(10));
      pick = $urandom_range(11);
      case (pick)
        0: prog.push_back(enc_r(7'h00, 3'd0, rd, rs1, rs2));
        1: prog.push_back(enc_r(7'h20, 3'd0, rd, rs1, rs2));
        2: prog.push_back(enc_r(7'h00, 3'd7, rd, rs1, rs2));
        3: prog.push_back(enc_r(7'h00, 3'd6, rd, rs1, rs2));
        4: prog.push_back(enc_r(7'h00, 3'd4, rd, rs1, rs2));
        5: prog.push_back(enc_addi(rd, rs1, 12'($urandom())));
        6: prog.push_back(enc_lui(rd, 20'($urandom())));
        7: prog.push_back(enc_lw(rd, 5'd10, 12'($urandom_range(63) * 4)));
        8: prog.push_back(enc_sw(rs2, 5'd10, 12'($urandom_range(63) * 4)));
        9: prog.push_back(enc_b(3'd0, rs1, rs2, 13'(($urandom_range(2) + 2) * 4)));
        10: prog.push_back(enc_b(3'd1, rs1, rs2, 13'(($urandom_range(2) + 2) * 4)));
        default: prog.push_back(enc_jal(rd, 21'(($urandom_range(2) + 2) * 4)));
      endcase
    end
    prog.push_back(EBREAK);
  endtask

  task automatic randomize_data();
    for (int w = 0; w < DATA_WORDS; w++) begin
      data[w] = $urandom();
    end
  endtask

  ////////////////////////////////////////
  // program run and compare
  ////////////////////////////////////////

  task automatic run_program(input string name, input logic contend);
    word_t       got;
    int unsigned n_ref;
    int unsigned adr;
    @(posedge clk);
    rst_req <= 1'b1;
    @(posedge clk);
    rst_req <= 1'b0;
    @(negedge clk);
    while (rst) @(negedge clk);
    check_flag("halted", halted, 1'b0);
    // program padded with zero words, which halt
    for (int w = 0; w < PROG_WORDS; w++) begin
      host_write(addr_t'(w * 4), (w < prog.size()) ? prog[w] : '0);
    end
    for (int w = 0; w < DATA_WORDS; w++) begin
      host_write(addr_t'((DATA_BASE + w) * 4), data[w]);
    end
    iss_mem = shadow;
    n_ref   = iss_run();
    if (n_ref >= MAX_INSTS) abort_run("reference model ran past the instruction limit");
    @(posedge clk);
    run <= 1'b1;
    @(negedge clk);
    while (!halted) begin
      // host reads of free memory at random cycles
      if (contend && $urandom_range(3) == 0) begin
        adr = FREE_BASE + $urandom_range(MEM_WORDS - FREE_BASE - 1);
        host_read(addr_t'(adr * 4), got);
        check_word($sformatf("host_rdt @%h", adr * 4), got, shadow[adr]);
      end else begin
        @(negedge clk);
        // core reads answer on their own port only
        check_flag("host_rsp_vld", host_rsp_vld, 1'b0);
      end
    end
    @(posedge clk);
    run <= 1'b0;
    repeat (4) begin
      @(negedge clk);
      check_flag("halted", halted, 1'b1);
    end
    for (int w = DATA_BASE; w < DATA_BASE + DATA_WORDS; w++) begin
      host_read(addr_t'(w * 4), got);
      check_word($sformatf("mem @%h", w * 4), got, iss_mem[w]);
      shadow[w] = iss_mem[w];
    end
    $display("%s program done, %0d instructions", name, n_ref);
  endtask

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    abort_run("core did not halt before the watchdog expired");
  end

  initial begin
    word_t       got;
    int unsigned adr;
    rst_req  = 1'b0;
    run      = 1'b0;
    host_req = '0;
    host_vld = 1'b0;
    void'($urandom(SEED));
    for (int w = 0; w < MEM_WORDS; w++) begin
      shadow[w] = '0;
    end
    @(negedge clk);
    while (rst) @(negedge clk);
    // host writes then reads back
    for (int w = FREE_BASE; w < MEM_WORDS; w++) begin
      host_write(addr_t'(w * 4), fill_word(w));
    end
    for (int w = 256; w < 272; w++) begin
      host_write(addr_t'(w * 4), $urandom());
    end
    for (int w = 256; w < 272; w++) begin
      host_read(addr_t'(w * 4), got);
      check_word($sformatf("host_rdt @%h", w * 4), got, shadow[w]);
    end
    repeat (16) begin
      adr = FREE_BASE + $urandom_range(MEM_WORDS - FREE_BASE - 1);
      host_read(addr_t'(adr * 4), got);
      check_word($sformatf("host_rdt @%h", adr * 4), got, fill_word(adr));
    end
    build_alu_prog();
    randomize_data();
    run_program("alu", 1'b0);
    build_copy_prog();
    randomize_data();
    run_program("copy", 1'b0);
    build_branch_prog();
    randomize_data();
    run_program("branch", 1'b0);
    build_random_prog();
    randomize_data();
    run_program("random", 1'b1);
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
core_pkg.sv
rv_decode.sv
rv_gpr.sv
rv_alu.sv
rv_core.sv
mem_arbiter.sv
sram_mem.sv
soc_top.sv
tb_clock.sv
tb_soc.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_soc
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= === FAIL ===
PASS_MSG  ?= === PASS ===

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
